//--- hdl/n64_rst_hk_pkg.sv
// N64 reset housekeeping definitions
// HDMI target resolution codes, configuration bundle,
// reset vector layout and default timing values
package n64_rst_hk_pkg;

  //////////////////////////////
  // Target resolution
  //////////////////////////////

  // Requested HDMI output resolution
  typedef logic [2:0] target_res_t;

  localparam target_res_t HDMI_TARGET_480P   = 3'd0;
  localparam target_res_t HDMI_TARGET_720P   = 3'd1;
  localparam target_res_t HDMI_TARGET_960P   = 3'd2;
  localparam target_res_t HDMI_TARGET_1080P  = 3'd3;
  localparam target_res_t HDMI_TARGET_1200P  = 3'd4;
  localparam target_res_t HDMI_TARGET_1440P  = 3'd5;
  localparam target_res_t HDMI_TARGET_1440WP = 3'd6;
  // Code 7 is reserved and runs on the main clock

  //////////////////////////////
  // Configuration bundle
  //////////////////////////////

  typedef struct packed {
    logic        interlaced;    // Source is interlaced
    logic        lowlatency;    // Low-latency output mode
    logic        vga_for_480p;  // 480p with VGA timing on the sub clock
    target_res_t target_res;
  } hk_cfg_t;

  //////////////////////////////
  // Reset vector
  //////////////////////////////

  // Active-low resets, one bit per consumer
  typedef logic [4:0] rst_vec_t;

  localparam int RST_N64   = 0;
  localparam int RST_HDMI  = 1;
  localparam int RST_CTRL  = 2;
  localparam int RST_SYS   = 3;
  localparam int RST_AUDIO = 4;

  // Default delays in N64 clock cycles
  localparam int DEF_N64_BOOT = 255;
  localparam int DEF_SYS_BOOT = 15;
  localparam int DEF_RST_LEN  = 4;

endpackage

//--- hdl/n64_cfg_sync.sv
// Input synchronizer for the reset housekeeping
// Two-flop synchronizer for the console reset, the
// configuration bundle and the PLL / transmitter status levels
`timescale 1ns/1ps

module n64_cfg_sync
  import n64_rst_hk_pkg::*;
(
  input  logic    N64_CLK_i,
  input  logic    rst_n_i,
  input  logic    n64_nrst_i,
  input  hk_cfg_t cfg_i,
  input  logic    si_cfg_done_i,
  input  logic    pll_locked_i,
  output logic    n64_nrst_o,
  output hk_cfg_t cfg_o,
  output logic    si_cfg_done_o,
  output logic    pll_locked_o
);

  // First stage, may go metastable
  logic    n64_nrst_meta;
  hk_cfg_t cfg_meta;
  logic    si_cfg_done_meta;
  logic    pll_locked_meta;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      // Hold the console in reset and all status low until sampled
      n64_nrst_meta    <= 1'b0;
      cfg_meta         <= '0;
      si_cfg_done_meta <= 1'b0;
      pll_locked_meta  <= 1'b0;
      n64_nrst_o       <= 1'b0;
      cfg_o            <= '0;
      si_cfg_done_o    <= 1'b0;
      pll_locked_o     <= 1'b0;
    end else begin
      n64_nrst_meta    <= n64_nrst_i;
      cfg_meta         <= cfg_i;
      si_cfg_done_meta <= si_cfg_done_i;
      pll_locked_meta  <= pll_locked_i;
      // Second stage, settled levels
      n64_nrst_o       <= n64_nrst_meta;
      cfg_o            <= cfg_meta;
      si_cfg_done_o    <= si_cfg_done_meta;
      pll_locked_o     <= pll_locked_meta;
    end
  end

endmodule

//--- hdl/n64_boot_delay.sv
// Power-on boot delay
// Releases the N64 side after a fixed delay and the
// system side after a further delay counted under PLL lock
`timescale 1ns/1ps

module n64_boot_delay #(
  parameter int N64_BOOT = 255,
  parameter int SYS_BOOT = 15
) (
  input  logic N64_CLK_i,
  input  logic rst_n_i,
  input  logic pll_locked_i,
  output logic n64_en_o,
  output logic sys_en_o
);

  typedef logic [$clog2(N64_BOOT+2)-1:0] n64_cnt_t;
  typedef logic [$clog2(SYS_BOOT+2)-1:0] sys_cnt_t;

  n64_cnt_t n64_cnt_q;
  sys_cnt_t sys_cnt_q;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      n64_cnt_q <= n64_cnt_t'(N64_BOOT);
      sys_cnt_q <= sys_cnt_t'(SYS_BOOT);
      n64_en_o  <= 1'b0;
      sys_en_o  <= 1'b0;
    end else begin
      // N64 side, free running down-count, sticky release
      if (!n64_en_o) begin
        if (n64_cnt_q > n64_cnt_t'(1)) n64_cnt_q <= n64_cnt_q - 1'b1;
        else n64_en_o <= 1'b1;
      end
      // System side starts after N64 release, pauses while unlocked
      if (n64_en_o && pll_locked_i && !sys_en_o) begin
        if (sys_cnt_q > sys_cnt_t'(1)) sys_cnt_q <= sys_cnt_q - 1'b1;
        else sys_en_o <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/hdmi_clk_selector.sv
// HDMI pixel clock selection
// Picks main or sub clock from the output configuration
// and flags every change of the registered selection
`timescale 1ns/1ps

module hdmi_clk_selector
  import n64_rst_hk_pkg::*;
(
  input  logic    N64_CLK_i,
  input  logic    rst_n_i,
  input  hk_cfg_t cfg_i,
  input  logic    n64_en_i,
  output logic    clk_sel_o,
  output logic    sel_change_o
);

  //////////////////////////////
  // Select rule
  //////////////////////////////

  // 1 selects the sub clock, 0 the main clock
  logic sel_nxt;
  logic res_sel;

  // Main clock for 720p, 1080p and 4:3 1440p
  // Sub clock for 960p, 1200p and 16:9 1440p
  always_comb begin
    case (cfg_i.target_res)
      HDMI_TARGET_480P:   res_sel = cfg_i.vga_for_480p;
      HDMI_TARGET_720P:   res_sel = 1'b0;
      HDMI_TARGET_960P:   res_sel = 1'b1;
      HDMI_TARGET_1080P:  res_sel = 1'b0;
      HDMI_TARGET_1200P:  res_sel = 1'b1;
      HDMI_TARGET_1440P:  res_sel = 1'b0;
      HDMI_TARGET_1440WP: res_sel = 1'b1;
      // Reserved code
      default:            res_sel = 1'b0;
    endcase
  end

  always_comb begin
    if (cfg_i.lowlatency) begin
      // Low latency follows the source scan type
      sel_nxt = cfg_i.interlaced;
    end else begin
      sel_nxt = res_sel;
    end
  end

  //////////////////////////////
  // Registered select and change flag
  //////////////////////////////

  logic sel_q;
  logic change_q;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      sel_q    <= 1'b0;
      change_q <= 1'b0;
    end else begin
      sel_q    <= sel_nxt;
      // High in the cycle the new select appears
      // Suppressed during boot, the HDMI path is in reset anyway
      change_q <= n64_en_i && (sel_nxt != sel_q);
    end
  end

  assign clk_sel_o    = sel_q;
  assign sel_change_o = change_q;

endmodule

//--- hdl/reset_generator.sv
// Reset stretcher
// Drops its reset one cycle after the source goes low and
// releases it after a number of enabled cycles with the source high
`timescale 1ns/1ps

module reset_generator #(
  parameter int RST_LEN = 4
) (
  input  logic N64_CLK_i,
  input  logic rst_n_i,
  input  logic clk_en_i,
  input  logic src_nrst_i,
  output logic rst_o
);

  typedef logic [$clog2(RST_LEN+1)-1:0] len_cnt_t;

  len_cnt_t cnt_q;
  logic     cnt_done;

  // Stretch length reached
  assign cnt_done = (cnt_q == len_cnt_t'(RST_LEN));

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      rst_o <= 1'b0;
    end else begin
      if (!src_nrst_i) begin
        // Source asserted, restart the stretch
        cnt_q <= '0;
      end else if (clk_en_i && !cnt_done) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Low as soon as the source drops
      rst_o <= src_nrst_i && cnt_done;
    end
  end

endmodule

//--- hdl/n64_rst_hk.sv
// N64 reset and clock-select housekeeping
// Boot delay, input synchronization, HDMI clock selection
// and stretched active-low resets for five consumers
`timescale 1ns/1ps

module n64_rst_hk
  import n64_rst_hk_pkg::*;
#(
  parameter int N64_BOOT = DEF_N64_BOOT,
  parameter int SYS_BOOT = DEF_SYS_BOOT,
  parameter int RST_LEN  = DEF_RST_LEN
) (
  input  logic     N64_CLK_i,
  input  logic     rst_n_i,
  input  logic     n64_nrst_i,
  input  hk_cfg_t  cfg_i,
  input  logic     si_cfg_done_i,
  input  logic     pll_locked_i,
  output rst_vec_t nrst_o,
  output logic     hdmi_clk_sel_o
);

  //////////////////////////////
  // Input side
  //////////////////////////////

  logic    n64_nrst_s;
  hk_cfg_t cfg_s;
  logic    si_cfg_done_s;
  logic    pll_locked_s;

  n64_cfg_sync n64_cfg_sync_inst (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .n64_nrst_i    (n64_nrst_i),
    .cfg_i         (cfg_i),
    .si_cfg_done_i (si_cfg_done_i),
    .pll_locked_i  (pll_locked_i),
    .n64_nrst_o    (n64_nrst_s),
    .cfg_o         (cfg_s),
    .si_cfg_done_o (si_cfg_done_s),
    .pll_locked_o  (pll_locked_s)
  );

  //////////////////////////////
  // Processing
  //////////////////////////////

  logic n64_en;
  logic sys_en;
  logic clk_sel;
  logic sel_change;

  n64_boot_delay #(
    .N64_BOOT (N64_BOOT),
    .SYS_BOOT (SYS_BOOT)
  ) n64_boot_delay_inst (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_s),
    .n64_en_o     (n64_en),
    .sys_en_o     (sys_en)
  );

  hdmi_clk_selector hdmi_clk_selector_inst (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg_s),
    .n64_en_i     (n64_en),
    .clk_sel_o    (clk_sel),
    .sel_change_o (sel_change)
  );

  // Select level for the external clock mux
  assign hdmi_clk_sel_o = clk_sel;

  //////////////////////////////
  // Output side
  //////////////////////////////

  rst_vec_t src_nrst;
  rst_vec_t clk_en;

  // Video input follows the console reset once booted
  assign src_nrst[RST_N64]   = n64_nrst_s;
  assign clk_en[RST_N64]     = n64_en;

  // HDMI also needs a configured transmitter
  // and is pulsed across a clock switch
  assign src_nrst[RST_HDMI]  = n64_en & n64_nrst_s & si_cfg_done_s & ~sel_change;
  assign clk_en[RST_HDMI]    = si_cfg_done_s;

  assign src_nrst[RST_CTRL]  = n64_nrst_s;
  assign clk_en[RST_CTRL]    = n64_en;

  // Soft CPU resets on power-up only, never from the console button
  assign src_nrst[RST_SYS]   = sys_en;
  assign clk_en[RST_SYS]     = pll_locked_s;

  // Audio clock runs freely
  assign src_nrst[RST_AUDIO] = n64_en & n64_nrst_s;
  assign clk_en[RST_AUDIO]   = 1'b1;

  for (genvar i = 0; i < $bits(rst_vec_t); i++) begin : g_rst
    reset_generator #(
      .RST_LEN (RST_LEN)
    ) reset_generator_inst (
      .N64_CLK_i  (N64_CLK_i),
      .rst_n_i    (rst_n_i),
      .clk_en_i   (clk_en[i]),
      .src_nrst_i (src_nrst[i]),
      .rst_o      (nrst_o[i])
    );
  end

endmodule

//--- tb/n64_rst_hk_checker.sv
// Timing checks for the reset housekeeping
// Console reset latency, change pulse width and reset levels
`timescale 1ns/1ps

module n64_rst_hk_checker
  import n64_rst_hk_pkg::*;
(
  input logic     N64_CLK_i,
  input logic     rst_n_i,
  input logic     n64_nrst_i,
  input logic     sel_change_i,
  input rst_vec_t nrst_i
);

  // Board reset seen on the previous edge
  logic in_rst_q;

  // Number of failed assertions
  int fail_cnt = 0;

  always_ff @(posedge N64_CLK_i) begin
    in_rst_q <= !rst_n_i;
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Two sync stages plus the stretcher register
  a_n64_latency: assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
      ($fell(n64_nrst_i) && nrst_i[RST_N64]) |-> ##3 $fell(nrst_i[RST_N64])
  ) else begin
    $error("video input reset did not fall 3 cycles after the console reset");
    fail_cnt++;
  end

  // Change flag is a single-cycle pulse
  a_sel_pulse: assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
      sel_change_i |=> !sel_change_i
  ) else begin
    $error("select change pulse lasted more than one cycle");
    fail_cnt++;
  end

  // Every consumer held while the board is in reset
  a_rst_held: assert property (
    @(posedge N64_CLK_i)
      (in_rst_q && !rst_n_i) |-> (nrst_i == '0)
  ) else begin
    $error("a consumer reset was released during the board reset");
    fail_cnt++;
  end

  // Soft CPU reset never drops once released
  a_sys_sticky: assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
      !$fell(nrst_i[RST_SYS])
  ) else begin
    $error("soft CPU reset dropped outside the board reset");
    fail_cnt++;
  end

endmodule

bind n64_rst_hk n64_rst_hk_checker n64_rst_hk_checker_inst (
  .N64_CLK_i    (N64_CLK_i),
  .rst_n_i      (rst_n_i),
  .n64_nrst_i   (n64_nrst_i),
  .sel_change_i (sel_change),
  .nrst_i       (nrst_o)
);

//--- tb/n64_rst_hk_tb.sv
// Testbench for the N64 reset housekeeping block
// Applies a table of configuration and status levels, lets the resets settle
// and compares the HDMI clock select and the reset vector
`timescale 1ns/1ps

module n64_rst_hk_tb
  import n64_rst_hk_pkg::*;
();

  localparam int N64_BOOT       = 20;
  localparam int SYS_BOOT       = 6;
  localparam int RST_LEN        = 4;
  localparam int DRIVE_DLY      = 2;
  localparam int SETTLE         = 40;
  localparam int TABLE_ROWS     = 20;
  localparam int RAND_ROWS      = 8;
  localparam int TIMEOUT_CYCLES = (TABLE_ROWS + RAND_ROWS) * 60 + 200;

  // One stimulus row with its expected results
  typedef struct packed {
    hk_cfg_t  cfg;
    logic     n64_nrst;
    logic     si_cfg_done;
    logic     pll_locked;
    logic     exp_sel;
    rst_vec_t exp_rst;
  } row_t;

  logic     n64_clk;
  logic     rst_n;
  logic     n64_nrst;
  hk_cfg_t  cfg;
  logic     si_cfg_done;
  logic     pll_locked;
  rst_vec_t nrst;
  logic     hdmi_clk_sel;

  row_t   rows_q[$];
  int     sel_errs;
  int     rst_errs;
  int     pulse_errs;
  int     cycle_cnt = 0;
  integer seed;

  n64_rst_hk #(
    .N64_BOOT (N64_BOOT),
    .SYS_BOOT (SYS_BOOT),
    .RST_LEN  (RST_LEN)
  ) n64_rst_hk_inst (
    .N64_CLK_i      (n64_clk),
    .rst_n_i        (rst_n),
    .n64_nrst_i     (n64_nrst),
    .cfg_i          (cfg),
    .si_cfg_done_i  (si_cfg_done),
    .pll_locked_i   (pll_locked),
    .nrst_o         (nrst),
    .hdmi_clk_sel_o (hdmi_clk_sel)
  );

  //////////////////////////////
  // Clock and run limit
  //////////////////////////////

  initial n64_clk = 1'b0;
  always #10 n64_clk = ~n64_clk;

  always @(posedge n64_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic hk_cfg_t build_cfg(logic il, logic ll, logic vga, target_res_t res);
    hk_cfg_t c;
    c.interlaced   = il;
    c.lowlatency   = ll;
    c.vga_for_480p = vga;
    c.target_res   = res;
    return c;
  endfunction

  // Reference select where 1 picks the sub clock
  function automatic logic sub_clk_expected(hk_cfg_t c);
    if (c.lowlatency)
      return c.interlaced;
    if (c.target_res == HDMI_TARGET_480P)
      return c.vga_for_480p;
    return (c.target_res == HDMI_TARGET_960P) ||
           (c.target_res == HDMI_TARGET_1200P) ||
           (c.target_res == HDMI_TARGET_1440WP);
  endfunction

  task automatic check_sel(string what, logic got, logic exp);
    if (got !== exp) begin
      sel_errs++;
      $display("** Error at %0t ns: %s clock select got %b, expected %b",
               $time, what, got, exp);
    end
  endtask

  task automatic check_rst(string what, rst_vec_t got, rst_vec_t exp);
    if (got !== exp) begin
      rst_errs++;
      $display("** Error at %0t ns: %s reset vector got %b, expected %b",
               $time, what, got, exp);
    end
  endtask

  task automatic compare_low_cycles(string what, int got, int lo, int hi);
    if (got < lo || got > hi) begin
      pulse_errs++;
      $display("** Error at %0t ns: %s HDMI reset low for %0d cycles, expected %0d to %0d",
               $time, what, got, lo, hi);
    end
  endtask

  task automatic add_row(hk_cfg_t c, logic nrst_lvl, logic si_lvl, logic pll_lvl,
                         logic exp_sel, rst_vec_t exp_rst);
    row_t r;
    r.cfg         = c;
    r.n64_nrst    = nrst_lvl;
    r.si_cfg_done = si_lvl;
    r.pll_locked  = pll_lvl;
    r.exp_sel     = exp_sel;
    r.exp_rst     = exp_rst;
    rows_q.push_back(r);
  endtask

  task automatic fill_table();
    hk_cfg_t rcfg;
    int      rnd;
    // Boot with transmitter and PLL down, then PLL, then transmitter
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b1, 1'b0, 1'b0, 1'b0, 5'b10101);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b1, 1'b0, 1'b1, 1'b0, 5'b11101);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // Console reset pulse leaves the soft CPU untouched
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b0, 1'b1, 1'b1, 1'b0, 5'b01000);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // Walk through the resolution codes
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_960P), 1'b1, 1'b1, 1'b1, 1'b1, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_720P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_1080P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_1200P), 1'b1, 1'b1, 1'b1, 1'b1, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_1440P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_1440WP), 1'b1, 1'b1, 1'b1, 1'b1, 5'b11111);
    // Reserved code
    add_row(build_cfg(1'b0, 1'b0, 1'b0, 3'd7), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // 480p with and without VGA timing
    add_row(build_cfg(1'b0, 1'b0, 1'b1, HDMI_TARGET_480P), 1'b1, 1'b1, 1'b1, 1'b1, 5'b11111);
    add_row(build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // Low latency follows interlaced and ignores the resolution
    add_row(build_cfg(1'b1, 1'b1, 1'b0, HDMI_TARGET_720P), 1'b1, 1'b1, 1'b1, 1'b1, 5'b11111);
    add_row(build_cfg(1'b0, 1'b1, 1'b0, HDMI_TARGET_960P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    add_row(build_cfg(1'b1, 1'b0, 1'b0, HDMI_TARGET_1080P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // PLL drop after release leaves the soft CPU reset high
    add_row(build_cfg(1'b1, 1'b0, 1'b0, HDMI_TARGET_1080P), 1'b1, 1'b1, 1'b0, 1'b0, 5'b11111);
    add_row(build_cfg(1'b1, 1'b0, 1'b0, HDMI_TARGET_1080P), 1'b0, 1'b1, 1'b0, 1'b0, 5'b01000);
    add_row(build_cfg(1'b1, 1'b0, 1'b0, HDMI_TARGET_1080P), 1'b1, 1'b1, 1'b1, 1'b0, 5'b11111);
    // Random selector rows with everything up
    for (int k = 0; k < RAND_ROWS; k++) begin
      rnd  = $random(seed);
      rcfg = hk_cfg_t'(rnd[$bits(hk_cfg_t)-1:0]);
      add_row(rcfg, 1'b1, 1'b1, 1'b1, sub_clk_expected(rcfg), '1);
    end
  endtask

  task automatic apply_row(row_t r);
    @(posedge n64_clk);
    #DRIVE_DLY;
    cfg         = r.cfg;
    n64_nrst    = r.n64_nrst;
    si_cfg_done = r.si_cfg_done;
    pll_locked  = r.pll_locked;
  endtask

  // Mid-cycle samples count HDMI low cycles and AND all reset bits
  task automatic watch_settle(output int hdmi_low, output rst_vec_t hold);
    hdmi_low = 0;
    hold     = '1;
    repeat (SETTLE) begin
      @(negedge n64_clk);
      if (!nrst[RST_HDMI])
        hdmi_low++;
      hold &= nrst;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    row_t     r;
    logic     prev_sel;
    rst_vec_t prev_rst;
    int       hdmi_low;
    rst_vec_t hold;
    string    tag;
    int       assert_errs;

    seed        = 32'h9684_e522;
    sel_errs    = 0;
    rst_errs    = 0;
    pulse_errs  = 0;
    rst_n       = 1'b0;
    n64_nrst    = 1'b1;
    cfg         = build_cfg(1'b0, 1'b0, 1'b0, HDMI_TARGET_480P);
    si_cfg_done = 1'b0;
    pll_locked  = 1'b0;

    fill_table();

    repeat (4) @(posedge n64_clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // Still inside the boot delay
    repeat (N64_BOOT / 2) @(negedge n64_clk);
    check_rst("boot", nrst, '0);
    check_sel("boot", hdmi_clk_sel, 1'b0);

    prev_sel = 1'b0;
    prev_rst = '0;
    foreach (rows_q[i]) begin
      r   = rows_q[i];
      tag = $sformatf("row %0d", i);
      apply_row(r);
      watch_settle(hdmi_low, hold);
      check_sel(tag, hdmi_clk_sel, r.exp_sel);
      check_rst(tag, nrst, r.exp_rst);
      // On steady rows only HDMI may dip and only on a select change
      if (prev_rst == '1 && r.exp_rst == '1) begin
        check_rst(tag, hold | rst_vec_t'(1 << RST_HDMI), '1);
        if (r.exp_sel != prev_sel)
          compare_low_cycles(tag, hdmi_low, RST_LEN, SETTLE);
        else
          compare_low_cycles(tag, hdmi_low, 0, 0);
      end
      prev_sel = r.exp_sel;
      prev_rst = r.exp_rst;
    end

    assert_errs = n64_rst_hk_inst.n64_rst_hk_checker_inst.fail_cnt;
    $display("Summary: %0d select errors, %0d reset errors, %0d pulse errors, %0d assertion errors",
             sel_errs, rst_errs, pulse_errs, assert_errs);
    if (sel_errs + rst_errs + pulse_errs + assert_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- n64_rst_hk.f
hdl/n64_rst_hk_pkg.sv
hdl/n64_cfg_sync.sv
hdl/n64_boot_delay.sv
hdl/hdmi_clk_selector.sv
hdl/reset_generator.sv
hdl/n64_rst_hk.sv
tb/n64_rst_hk_checker.sv
tb/n64_rst_hk_tb.sv

//--- Bender.yml
package:
  name: n64_rst_hk

sources:
  # Package first, then the RTL in dependency order
  - files:
      - hdl/n64_rst_hk_pkg.sv
      - hdl/n64_cfg_sync.sv
      - hdl/n64_boot_delay.sv
      - hdl/hdmi_clk_selector.sv
      - hdl/reset_generator.sv
      - hdl/n64_rst_hk.sv

  # Checker and testbench
  - target: test
    files:
      - tb/n64_rst_hk_checker.sv
      - tb/n64_rst_hk_tb.sv
